/* common/sdio_pkg.sv */
`default_nettype none

package sdio_pkg;

  // Command frame bit positions, counted from the start bit as 0
  localparam int CMD_BIT_DIR       = 1;
  localparam int CMD_BIT_IDX_START = 2;
  localparam int CMD_BIT_IDX_END   = 7;
  localparam int CMD_BIT_ARG_START = 8;
  localparam int CMD_BIT_ARG_END   = 39;
  localparam int CMD_BIT_CRC_START = 40;
  localparam int CMD_BIT_CRC_END   = 46;
  localparam int CMD_BIT_END       = 47;

  // Response payload between start bit and CRC
  localparam int RSPS_W = 40;

  // CRC widths
  localparam int CRC7_W  = 7;
  localparam int CRC16_W = 16;

  // CRC status token returned on DAT0 after a write block
  localparam logic [2:0] TOKEN_GOOD = 3'b010;
  localparam logic [2:0] TOKEN_BAD  = 3'b101;

  // Byte count width, wide enough for 4096 byte blocks
  localparam int COUNT_W_DEFAULT = 13;

endpackage

`default_nettype wire

/* filelist.f */
common/sdio_pkg.sv
verilog/crc7.sv
verilog/crc16.sv
sdio_cmd_phy/sdio_cmd_phy.sv
sdio_data_phy/sdio_data_phy.sv
verilog/sdio_device_phy.sv
tb/tb_clk_gen.sv
tb/tb_sdio_device_phy.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_sdio_device_phy -o tb_sim

# The log decides the result, the pipe keeps set -e from ending early
./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "Simulation ended without completing"
  exit 1
fi
echo "Simulation passed"

/* sdio_cmd_phy/sdio_cmd_phy.sv */
`default_nettype none

module sdio_cmd_phy
  import sdio_pkg::*;
(
  input  wire               i_sdio_clk,
  input  wire               rst,
  input  wire               i_sdio_cmd_in,
  input  wire               i_rsps_stb,
  input  wire  [RSPS_W-1:0] i_rsps,
  input  wire               i_rsps_fail,
  output logic              o_sdio_cmd_out,
  output logic              o_sdio_cmd_dir,
  output logic              o_cmd_phy_idle,
  output logic              o_cmd_stb,
  output logic              o_cmd_crc_good_stb,
  output logic [5:0]        o_cmd,
  output logic [31:0]       o_cmd_arg,
  output logic              o_rsps_idle
);

  localparam logic [2:0] IDLE               = 3'd0;
  localparam logic [2:0] READ_COMMAND       = 3'd1;
  localparam logic [2:0] RESPONSE_DIR       = 3'd2;
  localparam logic [2:0] WAIT_RESPONSE      = 3'd3;
  localparam logic [2:0] RESPONSE           = 3'd4;
  localparam logic [2:0] RESPONSE_FIRST_CRC = 3'd5;
  localparam logic [2:0] RESPONSE_CRC       = 3'd6;
  localparam logic [2:0] RESPONSE_FINISHED  = 3'd7;

  logic [2:0]        state;
  logic [5:0]        bit_count;
  logic [CRC7_W-1:0] r_crc;
  logic [CRC7_W-1:0] crc;
  logic [RSPS_W-1:0] lcl_rsps;
  logic              crc_bit;
  logic              crc_en;
  logic              crc_clr;
  logic              in_idx;
  logic              in_arg;
  logic              in_crc;

  crc7 u_crc7 (
    .i_sdio_clk (i_sdio_clk),
    .i_clr      (crc_clr),
    .i_en       (crc_en),
    .i_bit      (crc_bit),
    .o_crc      (crc)
  );

  assign o_cmd_phy_idle = (state == IDLE) && i_sdio_cmd_in;

  // Which field of the incoming frame the current bit belongs to
  assign in_idx = (bit_count >= 6'(CMD_BIT_IDX_START)) && (bit_count <= 6'(CMD_BIT_IDX_END));
  assign in_arg = (bit_count >= 6'(CMD_BIT_ARG_START)) && (bit_count <= 6'(CMD_BIT_ARG_END));
  assign in_crc = (bit_count >= 6'(CMD_BIT_CRC_START)) && (bit_count <= 6'(CMD_BIT_CRC_END));

  // While transmitting, feed the bit about to go out so the CRC is ready on time
  assign crc_bit = o_sdio_cmd_dir ? lcl_rsps[RSPS_W-1] : i_sdio_cmd_in;

  // CRC runs from the start bit to the argument end and then holds for the compare
  assign crc_en = ((state == IDLE) && !i_sdio_cmd_in) ||
                  ((state == READ_COMMAND) && (bit_count <= 6'(CMD_BIT_ARG_END))) ||
                  (state == RESPONSE);

  assign crc_clr = rst || (state == RESPONSE_DIR) || ((state == IDLE) && i_sdio_cmd_in);

  // Control FSM
  always_ff @(posedge i_sdio_clk) begin
    if (rst) begin
      state              <= IDLE;
      bit_count          <= '0;
      o_sdio_cmd_out     <= 1'b1;
      o_sdio_cmd_dir     <= 1'b0;
      o_cmd_stb          <= 1'b0;
      o_cmd_crc_good_stb <= 1'b0;
      o_rsps_idle        <= 1'b0;
    end else begin
      o_cmd_stb          <= 1'b0;
      o_cmd_crc_good_stb <= 1'b0;
      bit_count          <= bit_count + 1'b1;

      case (state)
        IDLE: begin
          o_rsps_idle    <= 1'b1;
          o_sdio_cmd_out <= 1'b1;
          o_sdio_cmd_dir <= 1'b0;
          // Start bit is bit 0, so the next sample is bit 1
          bit_count      <= 6'd1;
          if (!i_sdio_cmd_in) begin
            o_rsps_idle <= 1'b0;
            state       <= READ_COMMAND;
          end
        end
        READ_COMMAND: begin
          if (bit_count == 6'(CMD_BIT_END + 1)) begin
            state <= RESPONSE_DIR;
          end
        end
        RESPONSE_DIR: begin
          o_cmd_stb          <= 1'b1;
          o_cmd_crc_good_stb <= (r_crc == crc);
          // Take the line and hold it high until the response starts
          o_sdio_cmd_out     <= 1'b1;
          o_sdio_cmd_dir     <= 1'b1;
          state              <= WAIT_RESPONSE;
        end
        WAIT_RESPONSE: begin
          if (i_rsps_stb) begin
            o_sdio_cmd_out <= 1'b0;
            bit_count      <= '0;
            state          <= RESPONSE;
          end
        end
        RESPONSE: begin
          o_sdio_cmd_out <= lcl_rsps[RSPS_W-1];
          if (bit_count == 6'(RSPS_W - 1)) begin
            state <= RESPONSE_FIRST_CRC;
          end
        end
        RESPONSE_FIRST_CRC: begin
          o_sdio_cmd_out <= crc[CRC7_W-1];
          bit_count      <= '0;
          state          <= RESPONSE_CRC;
        end
        RESPONSE_CRC: begin
          o_sdio_cmd_out <= r_crc[CRC7_W-1];
          if (bit_count == 6'(CRC7_W - 2)) begin
            state <= RESPONSE_FINISHED;
          end
        end
        RESPONSE_FINISHED: begin
          // End bit
          o_sdio_cmd_out <= 1'b1;
          state          <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase

      // Link gave up on this command so the line is dropped
      if (i_rsps_fail) begin
        state          <= IDLE;
        o_sdio_cmd_out <= 1'b1;
        o_sdio_cmd_dir <= 1'b0;
      end
    end
  end

  // Frame fields and response shift registers
  always_ff @(posedge i_sdio_clk) begin
    case (state)
      READ_COMMAND: begin
        if (in_idx) begin
          o_cmd <= {o_cmd[4:0], i_sdio_cmd_in};
        end
        if (in_arg) begin
          o_cmd_arg <= {o_cmd_arg[30:0], i_sdio_cmd_in};
        end
        if (in_crc) begin
          r_crc <= {r_crc[CRC7_W-2:0], i_sdio_cmd_in};
        end
      end
      WAIT_RESPONSE: begin
        if (i_rsps_stb) begin
          lcl_rsps <= i_rsps;
        end
      end
      RESPONSE: begin
        lcl_rsps <= {lcl_rsps[RSPS_W-2:0], 1'b0};
      end
      RESPONSE_FIRST_CRC: begin
        r_crc <= {crc[CRC7_W-2:0], 1'b0};
      end
      RESPONSE_CRC: begin
        r_crc <= {r_crc[CRC7_W-2:0], 1'b0};
      end
      default: begin
      end
    endcase
  end

  // A response can only start once the line has been turned around
  a_rsps_dir: assert property (@(posedge i_sdio_clk) disable iff (rst)
    ((state == WAIT_RESPONSE) && i_rsps_stb) |-> o_sdio_cmd_dir);

  // The link never sees idle while the device still drives CMD
  a_idle_dir: assert property (@(posedge i_sdio_clk) disable iff (rst)
    o_rsps_idle |-> !o_sdio_cmd_dir);

endmodule

`default_nettype wire

/* sdio_data_phy/sdio_data_phy.sv */
`default_nettype none

module sdio_data_phy
  import sdio_pkg::*;
#(
  parameter int COUNT_W = COUNT_W_DEFAULT
) (
  input  wire                i_sdio_clk,
  input  wire                rst,
  input  wire                i_activate,
  input  wire                i_write_flag,
  input  wire  [COUNT_W-1:0] i_data_count,
  input  wire                i_data_rd_stb,
  input  wire  [7:0]         i_data_rd_data,
  input  wire  [3:0]         i_sdio_data_in,
  output logic               o_finished,
  output logic               o_data_wr_stb,
  output logic [7:0]         o_data_wr_data,
  output logic               o_data_hst_rdy,
  output logic [3:0]         o_sdio_data_dir,
  output logic [3:0]         o_sdio_data_out
);

  localparam logic [3:0] IDLE     = 4'd0;
  localparam logic [3:0] WR_WAIT  = 4'd1;
  localparam logic [3:0] WR_DATA  = 4'd2;
  localparam logic [3:0] WR_CRC   = 4'd3;
  localparam logic [3:0] WR_END   = 4'd4;
  localparam logic [3:0] WR_GAP   = 4'd5;
  localparam logic [3:0] WR_TOKEN = 4'd6;
  localparam logic [3:0] RD_FETCH = 4'd7;
  localparam logic [3:0] RD_DATA  = 4'd8;
  localparam logic [3:0] RD_CRC   = 4'd9;
  localparam logic [3:0] RD_END   = 4'd10;
  localparam logic [3:0] DONE     = 4'd11;

  logic [3:0]              state;
  logic [COUNT_W-1:0]      bytes_left;
  logic                    phase;
  logic [3:0]              cnt;
  logic [3:0]              rx_hi;
  logic [7:0]              tx_byte;
  logic [7:0]              cur_byte;
  logic [3:0]              tx_nib;
  logic [3:0]              tok_sr;
  logic                    last_byte;
  logic                    crc_ok;
  logic                    crc_clr;
  logic                    crc_en;
  logic [3:0]              crc_bit;
  logic [3:0]              crc_msb;
  logic [3:0][CRC16_W-1:0] lane_crc;

  for (genvar i = 0; i < 4; i++) begin : g_lane
    crc16 u_crc16 (
      .i_sdio_clk (i_sdio_clk),
      .i_clr      (crc_clr),
      .i_en       (crc_en),
      .i_bit      (crc_bit[i]),
      .o_crc      (lane_crc[i])
    );
    assign crc_msb[i] = lane_crc[i][CRC16_W-1];
  end

  assign last_byte = (bytes_left == COUNT_W'(1));

  // Received CRC is run through the generator, a good lane ends at zero
  assign crc_ok = (lane_crc == '0);

  // Next byte arrives live on the high nibble cycle
  assign cur_byte = i_data_rd_stb ? i_data_rd_data : tx_byte;
  assign tx_nib   = phase ? tx_byte[3:0] : cur_byte[7:4];

  assign crc_clr = rst || (state == IDLE);
  assign crc_en  = (state inside {WR_DATA, WR_CRC, RD_DATA, RD_CRC});

  // Feeding the MSB back turns the generator into a plain shifter
  assign crc_bit = (state == RD_DATA) ? tx_nib :
                   (state == RD_CRC)  ? crc_msb : i_sdio_data_in;

  always_ff @(posedge i_sdio_clk) begin
    if (rst) begin
      state           <= IDLE;
      bytes_left      <= '0;
      phase           <= 1'b0;
      cnt             <= '0;
      o_finished      <= 1'b0;
      o_data_wr_stb   <= 1'b0;
      o_data_hst_rdy  <= 1'b0;
      o_sdio_data_dir <= 4'h0;
      o_sdio_data_out <= 4'hF;
    end else begin
      o_finished     <= 1'b0;
      o_data_wr_stb  <= 1'b0;
      o_data_hst_rdy <= 1'b0;

      case (state)
        IDLE: begin
          o_sdio_data_dir <= 4'h0;
          o_sdio_data_out <= 4'hF;
          phase           <= 1'b0;
          cnt             <= '0;
          if (i_activate) begin
            bytes_left <= i_data_count;
            if (i_write_flag) begin
              state <= WR_WAIT;
            end else begin
              // Ask for the first byte right away
              o_data_hst_rdy <= 1'b1;
              state          <= RD_FETCH;
            end
          end
        end
        WR_WAIT: begin
          if (i_sdio_data_in == 4'h0) begin
            state <= WR_DATA;
          end
        end
        WR_DATA: begin
          phase <= !phase;
          if (phase) begin
            o_data_wr_stb <= 1'b1;
            bytes_left    <= bytes_left - 1'b1;
            if (last_byte) begin
              state <= WR_CRC;
            end
          end
        end
        WR_CRC: begin
          cnt <= cnt + 1'b1;
          if (cnt == 4'(CRC16_W - 1)) begin
            cnt   <= '0;
            state <= WR_END;
          end
        end
        WR_END: begin
          state <= WR_GAP;
        end
        WR_GAP: begin
          cnt <= cnt + 1'b1;
          if (cnt == 4'd1) begin
            // Token start bit on DAT0 only
            cnt             <= '0;
            o_sdio_data_dir <= 4'b0001;
            o_sdio_data_out <= 4'b1110;
            state           <= WR_TOKEN;
          end
        end
        WR_TOKEN: begin
          cnt             <= cnt + 1'b1;
          o_sdio_data_out <= {3'b111, tok_sr[3]};
          if (cnt == 4'd3) begin
            state <= DONE;
          end
        end
        RD_FETCH: begin
          if (i_data_rd_stb) begin
            o_sdio_data_dir <= 4'hF;
            o_sdio_data_out <= 4'h0;
            state           <= RD_DATA;
          end
        end
        RD_DATA: begin
          phase           <= !phase;
          o_sdio_data_out <= tx_nib;
          if (!phase && !last_byte) begin
            o_data_hst_rdy <= 1'b1;
          end
          if (phase) begin
            bytes_left <= bytes_left - 1'b1;
            if (last_byte) begin
              state <= RD_CRC;
            end
          end
        end
        RD_CRC: begin
          o_sdio_data_out <= crc_msb;
          cnt             <= cnt + 1'b1;
          if (cnt == 4'(CRC16_W - 1)) begin
            cnt   <= '0;
            state <= RD_END;
          end
        end
        RD_END: begin
          o_sdio_data_out <= 4'hF;
          state           <= DONE;
        end
        DONE: begin
          o_sdio_data_dir <= 4'h0;
          o_sdio_data_out <= 4'hF;
          o_finished      <= 1'b1;
          state           <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Byte buffers and token shifter
  always_ff @(posedge i_sdio_clk) begin
    if (i_data_rd_stb) begin
      tx_byte <= i_data_rd_data;
    end
    if (state == WR_DATA) begin
      if (phase) begin
        o_data_wr_data <= {rx_hi, i_sdio_data_in};
      end else begin
        rx_hi <= i_sdio_data_in;
      end
    end
    // Token bits plus the end bit
    if (state == WR_END) begin
      tok_sr <= crc_ok ? {TOKEN_GOOD, 1'b1} : {TOKEN_BAD, 1'b1};
    end else if (state == WR_TOKEN) begin
      tok_sr <= {tok_sr[2:0], 1'b1};
    end
  end

  // The bus cannot pause mid block, so every request is answered at once
  a_rd_answer: assert property (@(posedge i_sdio_clk) disable iff (rst)
    o_data_hst_rdy |=> i_data_rd_stb);

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic o_clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // Free running host clock
  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_sdio_device_phy.sv */
`default_nettype none

module tb_sdio_device_phy
  import sdio_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int COUNT_W     = COUNT_W_DEFAULT;
  localparam int TIMEOUT     = 2000;
  localparam int BLOCK_BYTES = 16;

  logic               sdio_clk;
  logic               rst;
  logic               sdio_cmd_in;
  logic               sdio_cmd_out;
  logic               sdio_cmd_dir;
  logic               cmd_phy_idle;
  logic               cmd_stb;
  logic               cmd_crc_good_stb;
  logic [5:0]         cmd;
  logic [31:0]        cmd_arg;
  logic               rsps_stb;
  logic [RSPS_W-1:0]  rsps;
  logic               rsps_fail;
  logic               rsps_idle;
  logic               data_activate;
  logic               data_finished;
  logic               write_flag;
  logic [COUNT_W-1:0] data_count;
  logic               data_wr_stb;
  logic [7:0]         data_wr_data;
  logic               data_rd_stb;
  logic [7:0]         data_rd_data;
  logic               data_hst_rdy;
  logic [3:0]         sdio_data_dir;
  logic [3:0]         sdio_data_in;
  logic [3:0]         sdio_data_out;

  logic [15:0]        lfsr_state;
  logic [7:0]         block_bytes[$];
  logic [3:0]         block_nibs[$];

  tb_clk_gen #(.PERIOD_NS(40)) u_tb_clk_gen (.o_clk(sdio_clk));

  sdio_device_phy #(
    .COUNT_W (COUNT_W)
  ) u_sdio_device_phy (
    .i_sdio_clk         (sdio_clk),
    .rst                (rst),
    .i_sdio_cmd_in      (sdio_cmd_in),
    .o_sdio_cmd_out     (sdio_cmd_out),
    .o_sdio_cmd_dir     (sdio_cmd_dir),
    .o_cmd_phy_idle     (cmd_phy_idle),
    .o_cmd_stb          (cmd_stb),
    .o_cmd_crc_good_stb (cmd_crc_good_stb),
    .o_cmd              (cmd),
    .o_cmd_arg          (cmd_arg),
    .i_rsps_stb         (rsps_stb),
    .i_rsps             (rsps),
    .i_rsps_fail        (rsps_fail),
    .o_rsps_idle        (rsps_idle),
    .i_data_activate    (data_activate),
    .o_data_finished    (data_finished),
    .i_write_flag       (write_flag),
    .i_data_count       (data_count),
    .o_data_wr_stb      (data_wr_stb),
    .o_data_wr_data     (data_wr_data),
    .i_data_rd_stb      (data_rd_stb),
    .i_data_rd_data     (data_rd_data),
    .o_data_hst_rdy     (data_hst_rdy),
    .o_sdio_data_dir    (sdio_data_dir),
    .i_sdio_data_in     (sdio_data_in),
    .o_sdio_data_out    (sdio_data_out)
  );

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] random_word(input int n);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w = {w[62:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [63:0] w;
    w = random_word(8);
    return w[7:0];
  endfunction

  // CRC7 over the low n bits, MSB first
  function automatic logic [6:0] crc7_of(input logic [63:0] data, input int n);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = n - 1; i >= 0; i--) begin
      fb  = data[i] ^ crc[6];
      crc = {crc[5:0], 1'b0};
      if (fb) crc = crc ^ 7'h09;
    end
    return crc;
  endfunction

  function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic b);
    logic [15:0] nxt;
    nxt = {crc[14:0], 1'b0};
    if (b ^ crc[15]) nxt = nxt ^ 16'h1021;
    return nxt;
  endfunction

  // Full DAT stream of block_bytes: start nibble, data, lane CRCs, end nibble
  task automatic build_block_nibbles();
    logic [15:0] lane_crcs[4];
    logic [3:0]  nib;
    block_nibs.delete();
    block_nibs.push_back(4'h0);
    for (int l = 0; l < 4; l++) lane_crcs[l] = '0;
    foreach (block_bytes[i]) begin
      block_nibs.push_back(block_bytes[i][7:4]);
      block_nibs.push_back(block_bytes[i][3:0]);
      for (int l = 0; l < 4; l++) begin
        lane_crcs[l] = crc16_next(lane_crcs[l], block_bytes[i][4 + l]);
        lane_crcs[l] = crc16_next(lane_crcs[l], block_bytes[i][l]);
      end
    end
    for (int j = 0; j < 16; j++) begin
      for (int l = 0; l < 4; l++) nib[l] = lane_crcs[l][15 - j];
      block_nibs.push_back(nib);
    end
    block_nibs.push_back(4'hF);
  endtask

  task automatic verify_reset_outputs();
    @(posedge sdio_clk);
    check_value("o_cmd_phy_idle", cmd_phy_idle, 1);
    check_value("o_sdio_cmd_dir", sdio_cmd_dir, 0);
    check_value("o_sdio_cmd_out", sdio_cmd_out, 1);
    check_value("o_sdio_data_dir", sdio_data_dir, 0);
    check_value("o_sdio_data_out", sdio_data_out, 4'hF);
    check_value("o_rsps_idle", rsps_idle, 0);
    @(posedge sdio_clk);
    check_value("o_rsps_idle", rsps_idle, 1);
  endtask

  task automatic receive_command(input logic bad_crc);
    logic [47:0] frame;
    logic [63:0] w;
    logic [5:0]  idx;
    logic [31:0] arg;
    logic [6:0]  crc;
    logic        done;
    w   = random_word(38);
    idx = w[37:32];
    arg = w[31:0];
    // frame[47 - k] holds bit k of the command
    frame = '1;
    frame[47] = 1'b0;
    frame[47 - CMD_BIT_DIR] = 1'b1;
    for (int k = 0; k < 6; k++) frame[47 - (CMD_BIT_IDX_START + k)] = idx[5 - k];
    for (int k = 0; k < 32; k++) frame[47 - (CMD_BIT_ARG_START + k)] = arg[31 - k];
    crc = crc7_of(64'(frame >> (47 - CMD_BIT_ARG_END)), CMD_BIT_ARG_END + 1);
    if (bad_crc) crc = crc ^ 7'h04;
    for (int k = 0; k < 7; k++) frame[47 - (CMD_BIT_CRC_START + k)] = crc[6 - k];
    frame[47 - CMD_BIT_END] = 1'b1;
    for (int k = 0; k < 48; k++) begin
      @(posedge sdio_clk);
      sdio_cmd_in <= frame[47 - k];
    end
    @(posedge sdio_clk);
    sdio_cmd_in <= 1'b1;
    done = 1'b0;
    for (int n = 0; n < TIMEOUT && !done; n++) begin
      @(posedge sdio_clk);
      if (cmd_stb) begin
        done = 1'b1;
        check_value("o_cmd", cmd, idx);
        check_value("o_cmd_arg", cmd_arg, arg);
        check_value("o_cmd_crc_good_stb", cmd_crc_good_stb, !bad_crc);
        check_value("o_sdio_cmd_dir", sdio_cmd_dir, 1);
        check_value("o_sdio_cmd_out", sdio_cmd_out, 1);
      end
    end
    if (!done) stop_with_failure("No command strobe after a complete command frame");
  endtask

  task automatic respond_to_command();
    logic [63:0]       w;
    logic [RSPS_W-1:0] value;
    logic [48:0]       exp_bits;
    logic [48:0]       got_bits;
    logic              started;
    logic              done;
    int                nbits;
    w        = random_word(RSPS_W);
    value    = w[RSPS_W-1:0];
    exp_bits = {1'b0, value, crc7_of({24'd0, value}, RSPS_W), 1'b1};
    got_bits = '0;
    started  = 1'b0;
    done     = 1'b0;
    nbits    = 0;
    @(posedge sdio_clk);
    rsps_stb <= 1'b1;
    rsps     <= value;
    for (int n = 0; n < TIMEOUT && !done; n++) begin
      @(posedge sdio_clk);
      rsps_stb <= 1'b0;
      if (!sdio_cmd_dir) begin
        done = 1'b1;
      end else if (started || !sdio_cmd_out) begin
        started  = 1'b1;
        got_bits = {got_bits[47:0], sdio_cmd_out};
        nbits++;
      end
    end
    if (!done) stop_with_failure("CMD was not handed back to the host after the response");
    check_value("response bit count", nbits, 49);
    check_value("o_sdio_cmd_out response", got_bits, exp_bits);
  endtask

  task automatic abort_response();
    logic [63:0] w;
    logic        done;
    check_value("o_rsps_idle", rsps_idle, 0);
    @(posedge sdio_clk);
    rsps_fail <= 1'b1;
    @(posedge sdio_clk);
    rsps_fail <= 1'b0;
    done = 1'b0;
    for (int n = 0; n < TIMEOUT && !done; n++) begin
      @(posedge sdio_clk);
      done = rsps_idle;
    end
    if (!done) stop_with_failure("Command block did not return to idle after the abort");
    check_value("o_sdio_cmd_dir", sdio_cmd_dir, 0);
    check_value("o_sdio_cmd_out", sdio_cmd_out, 1);
    // A late response must leave CMD untouched
    w = random_word(RSPS_W);
    rsps_stb <= 1'b1;
    rsps     <= w[RSPS_W-1:0];
    for (int n = 0; n < 60; n++) begin
      @(posedge sdio_clk);
      rsps_stb <= 1'b0;
      check_value("o_sdio_cmd_dir", sdio_cmd_dir, 0);
      check_value("o_sdio_cmd_out", sdio_cmd_out, 1);
    end
  endtask

  task automatic write_block(input logic corrupt);
    logic [7:0] got[$];
    logic [3:0] host_nibs[$];
    logic [4:0] token;
    logic [4:0] exp_token;
    logic       done;
    int         ntok;
    block_bytes.delete();
    for (int i = 0; i < BLOCK_BYTES; i++) block_bytes.push_back(random_byte());
    build_block_nibbles();
    host_nibs = block_nibs;
    // Damage lane 2 in the first CRC nibble
    if (corrupt) host_nibs[1 + 2 * BLOCK_BYTES] = host_nibs[1 + 2 * BLOCK_BYTES] ^ 4'b0100;
    exp_token = {1'b0, (corrupt ? TOKEN_BAD : TOKEN_GOOD), 1'b1};
    @(posedge sdio_clk);
    data_activate <= 1'b1;
    write_flag    <= 1'b1;
    data_count    <= COUNT_W'(BLOCK_BYTES);
    @(posedge sdio_clk);
    data_activate <= 1'b0;
    token = '0;
    ntok  = 0;
    done  = 1'b0;
    for (int n = 0; n < TIMEOUT && !done; n++) begin
      @(posedge sdio_clk);
      if (data_wr_stb) got.push_back(data_wr_data);
      if (sdio_data_dir[0]) begin
        token = {token[3:0], sdio_data_out[0]};
        ntok++;
      end
      if (data_finished) begin
        done = 1'b1;
        check_value("o_sdio_data_dir", sdio_data_dir, 0);
      end
      if (host_nibs.size() > 0) sdio_data_in <= host_nibs.pop_front();
      else sdio_data_in <= 4'hF;
    end
    if (!done) stop_with_failure("No finished pulse after the block write");
    check_value("written byte count", got.size(), BLOCK_BYTES);
    foreach (got[i]) check_value("o_data_wr_data", got[i], block_bytes[i]);
    check_value("CRC status length", ntok, 5);
    check_value("CRC status token", token, exp_token);
  endtask

  task automatic read_block();
    logic [3:0] got[$];
    logic [7:0] b;
    logic       done;
    block_bytes.delete();
    @(posedge sdio_clk);
    data_activate <= 1'b1;
    write_flag    <= 1'b0;
    data_count    <= COUNT_W'(BLOCK_BYTES);
    @(posedge sdio_clk);
    data_activate <= 1'b0;
    done = 1'b0;
    for (int n = 0; n < TIMEOUT && !done; n++) begin
      @(posedge sdio_clk);
      // Link model answers each request in the next cycle
      if (data_hst_rdy) begin
        b = random_byte();
        block_bytes.push_back(b);
        data_rd_stb  <= 1'b1;
        data_rd_data <= b;
      end else begin
        data_rd_stb <= 1'b0;
      end
      if (sdio_data_dir == 4'hF) got.push_back(sdio_data_out);
      if (data_finished) begin
        done = 1'b1;
        check_value("o_sdio_data_dir", sdio_data_dir, 0);
      end
    end
    if (!done) stop_with_failure("No finished pulse after the block read");
    check_value("read byte requests", block_bytes.size(), BLOCK_BYTES);
    build_block_nibbles();
    check_value("DAT nibble count", got.size(), block_nibs.size());
    foreach (got[i]) check_value("o_sdio_data_out", got[i], block_nibs[i]);
  endtask

  initial begin
    lfsr_state    = 16'd63;
    rst           = 1'b1;
    sdio_cmd_in   = 1'b1;
    rsps_stb      = 1'b0;
    rsps          = '0;
    rsps_fail     = 1'b0;
    data_activate = 1'b0;
    write_flag    = 1'b0;
    data_count    = '0;
    data_rd_stb   = 1'b0;
    data_rd_data  = '0;
    sdio_data_in  = 4'hF;
    repeat (4) @(posedge sdio_clk);
    rst <= 1'b0;
    verify_reset_outputs();
    receive_command(1'b0);
    respond_to_command();
    receive_command(1'b1);
    abort_response();
    write_block(1'b0);
    write_block(1'b1);
    read_block();
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/crc16.sv */
`default_nettype none

module crc16
  import sdio_pkg::*;
(
  input  wire                i_sdio_clk,
  input  wire                i_clr,
  input  wire                i_en,
  input  wire                i_bit,
  output logic [CRC16_W-1:0] o_crc
);

  logic fb;

  // CCITT polynomial x^16 + x^12 + x^5 + 1, zero seed
  assign fb = i_bit ^ o_crc[CRC16_W-1];

  always_ff @(posedge i_sdio_clk) begin
    if (i_clr) begin
      o_crc <= '0;
    end else if (i_en) begin
      o_crc <= {o_crc[CRC16_W-2:12], o_crc[11] ^ fb, o_crc[10:5], o_crc[4] ^ fb,
                o_crc[3:0], fb};
    end
  end

endmodule

`default_nettype wire

/* verilog/crc7.sv */
`default_nettype none

module crc7
  import sdio_pkg::*;
(
  input  wire               i_sdio_clk,
  input  wire               i_clr,
  input  wire               i_en,
  input  wire               i_bit,
  output logic [CRC7_W-1:0] o_crc
);

  logic fb;

  // Polynomial x^7 + x^3 + 1, MSB first
  assign fb = i_bit ^ o_crc[CRC7_W-1];

  always_ff @(posedge i_sdio_clk) begin
    if (i_clr) begin
      o_crc <= '0;
    end else if (i_en) begin
      o_crc <= {o_crc[CRC7_W-2:3], o_crc[2] ^ fb, o_crc[1:0], fb};
    end
  end

endmodule

`default_nettype wire

/* verilog/sdio_device_phy.sv */
`default_nettype none

module sdio_device_phy
  import sdio_pkg::*;
#(
  parameter int COUNT_W = COUNT_W_DEFAULT
) (
  input  wire                i_sdio_clk,
  input  wire                rst,

  // CMD pad
  input  wire                i_sdio_cmd_in,
  output logic               o_sdio_cmd_out,
  output logic               o_sdio_cmd_dir,

  // Command side of the link
  output logic               o_cmd_phy_idle,
  output logic               o_cmd_stb,
  output logic               o_cmd_crc_good_stb,
  output logic [5:0]         o_cmd,
  output logic [31:0]        o_cmd_arg,
  input  wire                i_rsps_stb,
  input  wire  [RSPS_W-1:0]  i_rsps,
  input  wire                i_rsps_fail,
  output logic               o_rsps_idle,

  // Data side of the link
  input  wire                i_data_activate,
  output logic               o_data_finished,
  input  wire                i_write_flag,
  input  wire  [COUNT_W-1:0] i_data_count,
  output logic               o_data_wr_stb,
  output logic [7:0]         o_data_wr_data,
  input  wire                i_data_rd_stb,
  input  wire  [7:0]         i_data_rd_data,
  output logic               o_data_hst_rdy,

  // DAT pads
  output logic [3:0]         o_sdio_data_dir,
  input  wire  [3:0]         i_sdio_data_in,
  output logic [3:0]         o_sdio_data_out
);

  sdio_cmd_phy u_sdio_cmd_phy (
    .i_sdio_clk         (i_sdio_clk),
    .rst                (rst),
    .i_sdio_cmd_in      (i_sdio_cmd_in),
    .i_rsps_stb         (i_rsps_stb),
    .i_rsps             (i_rsps),
    .i_rsps_fail        (i_rsps_fail),
    .o_sdio_cmd_out     (o_sdio_cmd_out),
    .o_sdio_cmd_dir     (o_sdio_cmd_dir),
    .o_cmd_phy_idle     (o_cmd_phy_idle),
    .o_cmd_stb          (o_cmd_stb),
    .o_cmd_crc_good_stb (o_cmd_crc_good_stb),
    .o_cmd              (o_cmd),
    .o_cmd_arg          (o_cmd_arg),
    .o_rsps_idle        (o_rsps_idle)
  );

  sdio_data_phy #(
    .COUNT_W (COUNT_W)
  ) u_sdio_data_phy (
    .i_sdio_clk      (i_sdio_clk),
    .rst             (rst),
    .i_activate      (i_data_activate),
    .i_write_flag    (i_write_flag),
    .i_data_count    (i_data_count),
    .i_data_rd_stb   (i_data_rd_stb),
    .i_data_rd_data  (i_data_rd_data),
    .i_sdio_data_in  (i_sdio_data_in),
    .o_finished      (o_data_finished),
    .o_data_wr_stb   (o_data_wr_stb),
    .o_data_wr_data  (o_data_wr_data),
    .o_data_hst_rdy  (o_data_hst_rdy),
    .o_sdio_data_dir (o_sdio_data_dir),
    .o_sdio_data_out (o_sdio_data_out)
  );

endmodule

`default_nettype wire
